//--- design/zx_ports_macros.svh
// port block constants: bus widths and register reset values
`ifndef ZX_PORTS_MACROS_SVH
`define ZX_PORTS_MACROS_SVH

// bus widths
`define ZX_DATA_W     8
`define ZX_ADDR_W     16
`define ZX_NUM_PAGES  4

// configuration register reset values
`define MEMCONF_RST   8'h04   // rom mapped, no ram at 0000
`define SYSCONF_RST   8'h00   // 3.5 MHz
`define INTMASK_RST   8'h01   // frame interrupt only
`define FDDVIRT_RST   8'h00   // virtual drives off

// ram page reset values, 128K layout
`define PAGE0_RST     8'h00
`define PAGE1_RST     8'h05
`define PAGE2_RST     8'h02
`define PAGE3_RST     8'h00

`endif

//--- design/zx_port_pkg.sv
// port address and extended register index types for the I/O port block
`default_nettype none

`include "zx_ports_macros.svh"

package zx_port_pkg;

  // low address byte of the ports the block answers
  typedef enum logic [`ZX_DATA_W-1:0] {
    PORT_FE     = 8'hFE, // keyboard, tape, beeper, border
    PORT_FD     = 8'hFD, // 7FFD paging, AY when a15 high
    PORT_XT     = 8'hAF, // extended registers, index in a[15:8]
    PORT_COVOX  = 8'hFB,
    PORT_KJOY   = 8'h1F, // kempston joystick
    PORT_KMOUSE = 8'hDF, // kempston mouse
    PORT_SDCFG  = 8'h77, // Z-controller config
    PORT_SDDAT  = 8'h57  // Z-controller data
  } port_addr_e;

  // extended register index behind port AF
  typedef enum logic [`ZX_DATA_W-1:0] {
    XT_VCONF_STAT = 8'h00, // status on read
    XT_XBORDER    = 8'h0F,
    XT_RAMPAGE0   = 8'h10,
    XT_RAMPAGE1   = 8'h11,
    XT_RAMPAGE2   = 8'h12,
    XT_RAMPAGE3   = 8'h13,
    XT_FMADDR     = 8'h15,
    XT_SYSCONF    = 8'h20,
    XT_MEMCONF    = 8'h21,
    XT_INTMASK    = 8'h2A,
    XT_CACHECONF  = 8'h2B
  } xt_reg_e;

endpackage

`default_nettype wire

//--- design/zx_mem_pkg.sv
// memory paging types: page numbers, packed page set and 128K lock modes
`default_nettype none

`include "zx_ports_macros.svh"

package zx_mem_pkg;

  // memconf[7:6], selects how 7FFD bits 7:6 reach the page
  typedef enum logic [1:0] {
    LOCK_OFF_A = 2'b00, // fixed bit from memconf[6]
    LOCK_FIXED = 2'b01, // same, memconf[6] set
    LOCK_M1    = 2'b10, // sampled on opcode fetch
    LOCK_EXT   = 2'b11  // 1024K mode, no lock
  } lock_mode_e;

  typedef logic [`ZX_DATA_W-1:0] page_t;

  // page 0 sits in the low byte
  typedef page_t [`ZX_NUM_PAGES-1:0] xt_page_t;

endpackage

`default_nettype wire

//--- design/zx_port_decoder.sv
// port address decoder: port hit, read enable and single-cycle write strobes
`default_nettype none

`include "zx_ports_macros.svh"

module zx_port_decoder
  import zx_port_pkg::*;
(
  input  wire                  clk,
  input  wire [`ZX_ADDR_W-1:0] a,
  input  wire                  regs_we,
  input  wire                  iord,
  input  wire                  iowr_s,
  input  wire                  iord_s,
  output logic [`ZX_DATA_W-1:0] hoa,
  output logic                 porthit,
  output logic                 external_port,
  output logic                 dataout,
  output logic                 xt_wr,
  output logic                 xt_rd,
  output logic                 p7ffd_req,
  output logic                 beeper_wr,
  output logic                 border_wr,
  output logic                 covox_wr,
  output logic                 sdcfg_wr,
  output logic                 sddat_wr,
  output logic                 sddat_rd
);

  logic [`ZX_DATA_W-1:0] loa;

  assign loa = a[7:0];
  assign hoa = regs_we ? a[7:0] : a[15:8]; // register load indexes by low byte

  assign porthit = (loa == PORT_FE) || (loa == PORT_FD) || (loa == PORT_XT)
                || (loa == PORT_COVOX) || (loa == PORT_KJOY) || (loa == PORT_KMOUSE)
                || (loa == PORT_SDCFG) || (loa == PORT_SDDAT);

  assign external_port = (loa == PORT_FD) && a[15]; // AY lives outside
  assign dataout       = porthit && iord && !external_port;

  assign xt_wr     = ((loa == PORT_XT) && iowr_s) || regs_we;
  assign xt_rd     = (loa == PORT_XT) && iord_s;
  assign p7ffd_req = (loa == PORT_FD) && !a[15] && iowr_s;
  assign beeper_wr = (loa == PORT_FE) && iowr_s;
  assign border_wr = xt_wr && (hoa == XT_XBORDER);
  assign covox_wr  = (loa == PORT_COVOX) && iowr_s;
  assign sdcfg_wr  = (loa == PORT_SDCFG) && iowr_s;
  assign sddat_wr  = (loa == PORT_SDDAT) && iowr_s;
  assign sddat_rd  = (loa == PORT_SDDAT) && iord_s;

  // strobes to distinct devices never overlap
  a_one_dev_wr: assert property (@(posedge clk)
    $onehot0({beeper_wr, covox_wr, sdcfg_wr, sddat_wr}));

endmodule

`default_nettype wire

//--- design/paging_lock.sv
// 128K paging lock: lock-48 latch, opcode-fetch lock sample and 7FFD page
`default_nettype none

`include "zx_ports_macros.svh"

module paging_lock
  import zx_mem_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`ZX_DATA_W-1:0] din,
  input  wire                  opfetch,
  input  wire                  p7ffd_req,
  input  wire [`ZX_DATA_W-1:0] memconf,
  output logic                 p7ffd_wr,
  output page_t                page_7ffd
);

  lock_mode_e lock_mode;
  logic       m1_lock;
  logic       lock128;
  logic       lock48;

  assign lock_mode = lock_mode_e'(memconf[7:6]);

  always_ff @(posedge clk)
    if (rst)
      m1_lock <= 1'b0;
    else if (opfetch)
      m1_lock <= !(din[7] ^ din[6]); // opcode pattern decides the lock

  always_comb
  begin
    case (lock_mode)
      LOCK_EXT:              lock128 = 1'b0;
      LOCK_M1:               lock128 = m1_lock;
      LOCK_OFF_A, LOCK_FIXED: lock128 = memconf[6];
      default:               lock128 = memconf[6];
    endcase
  end

  // 1024K mode takes din[5] as the top page bit
  always_comb
  begin
    if (lock_mode == LOCK_EXT)
      page_7ffd = {2'b00, din[5], din[7:6], din[2:0]};
    else
      page_7ffd = {3'b000, lock128 ? 2'b00 : din[7:6], din[2:0]};
  end

  assign p7ffd_wr = p7ffd_req && !lock48;

  always_ff @(posedge clk)
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != LOCK_EXT))
      lock48 <= din[5];

  // once locked to 48K, the next request is refused
  a_lock48_holds: assert property (@(posedge clk) disable iff (rst)
    (p7ffd_wr && din[5] && (lock_mode != LOCK_EXT)) |=> !p7ffd_wr);

endmodule

`default_nettype wire

//--- design/xt_config_regs.sv
// extended configuration registers behind port AF, with the 7FFD page update
`default_nettype none

`include "zx_ports_macros.svh"

module xt_config_regs
  import zx_port_pkg::*;
  import zx_mem_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`ZX_DATA_W-1:0] din,
  input  wire [`ZX_DATA_W-1:0] hoa,
  input  wire                  xt_wr,
  input  wire                  p7ffd_wr,
  input  page_t                page_7ffd,
  output xt_page_t             xt_page,
  output logic [`ZX_DATA_W-1:0] memconf,
  output logic [`ZX_DATA_W-1:0] sysconf,
  output logic [3:0]           cacheconf,
  output logic [`ZX_DATA_W-1:0] intmask,
  output logic [4:0]           fmaddr
);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      memconf    <= `MEMCONF_RST;
      sysconf    <= `SYSCONF_RST;
      cacheconf  <= 4'h0;        // no cache
      intmask    <= `INTMASK_RST;
      fmaddr[4]  <= 1'b0;        // fm window off
      xt_page[0] <= `PAGE0_RST;
      xt_page[1] <= `PAGE1_RST;
      xt_page[2] <= `PAGE2_RST;
      xt_page[3] <= `PAGE3_RST;
    end
    else if (p7ffd_wr)
    begin
      // classic 128K write wins over the extended port
      xt_page[3] <= page_7ffd;
      memconf[0] <= din[4];      // rom select
    end
    else if (xt_wr)
    begin
      case (hoa)
        XT_RAMPAGE0, XT_RAMPAGE1, XT_RAMPAGE2, XT_RAMPAGE3:
          xt_page[hoa[1:0]] <= din;
        XT_FMADDR:
          fmaddr <= din[4:0];
        XT_SYSCONF:
        begin
          sysconf   <= din;
          cacheconf <= {4{din[2]}}; // cache follows turbo bit
        end
        XT_CACHECONF:
          cacheconf <= din[3:0];
        XT_MEMCONF:
          memconf <= din;
        XT_INTMASK:
          intmask <= din;
        default:
        begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/sd_port.sv
// Z-controller SD interface: chip select register, transfer start and data out
`default_nettype none

`include "zx_ports_macros.svh"

module sd_port (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`ZX_DATA_W-1:0] din,
  input  wire                  wr,
  input  wire                  sdcfg_wr,
  input  wire                  sddat_wr,
  input  wire                  sddat_rd,
  output logic                 sdcs_n,
  output logic                 sd_start,
  output logic [`ZX_DATA_W-1:0] sd_datain
);

  always_ff @(posedge clk)
    if (rst)
      sdcs_n <= 1'b1; // card deselected
    else if (sdcfg_wr)
      sdcs_n <= din[1];

  // every data access starts one spi byte
  assign sd_start  = sddat_wr || sddat_rd;
  assign sd_datain = wr ? din : 8'hFF; // reads clock out ones

endmodule

`default_nettype wire

//--- design/port_read_mux.sv
// port read multiplexer with the power-up status flag
`default_nettype none

`include "zx_ports_macros.svh"

module port_read_mux
  import zx_port_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`ZX_ADDR_W-1:0] a,
  input  wire [`ZX_DATA_W-1:0] hoa,
  input  wire                  xt_rd,
  input  wire [4:0]            keys_in,
  input  wire                  tape_read,
  input  wire [4:0]            kj_in,
  input  wire [7:0]            mus_in,
  input  wire [7:0]            sd_dataout,
  input  wire [`ZX_NUM_PAGES*`ZX_DATA_W-1:0] xt_page,
  output logic [`ZX_DATA_W-1:0] dout
);

  logic pwr_up;     // set until the first status read
  logic pwr_up_reg; // value shown in the status byte

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pwr_up     <= 1'b1;
      pwr_up_reg <= 1'b0;
    end
    else if (xt_rd && (hoa == XT_VCONF_STAT))
    begin
      pwr_up_reg <= pwr_up;
      pwr_up     <= 1'b0;
    end
  end

  always_comb
  begin
    case (a[7:0])
      PORT_FE:     dout = {1'b1, tape_read, 1'b0, keys_in};
      PORT_XT:
      begin
        case (hoa)
          XT_VCONF_STAT: dout = {1'b0, pwr_up_reg, 6'b000000};
          XT_RAMPAGE2:   dout = xt_page[2*`ZX_DATA_W +: `ZX_DATA_W];
          XT_RAMPAGE3:   dout = xt_page[3*`ZX_DATA_W +: `ZX_DATA_W];
          default:       dout = 8'hFF;
        endcase
      end
      PORT_KJOY:   dout = {3'b000, kj_in};
      PORT_KMOUSE: dout = mus_in;
      PORT_SDCFG:  dout = 8'h00;       // card present, writable
      PORT_SDDAT:  dout = sd_dataout;
      default:     dout = 8'hFF;       // floating bus
    endcase
  end

endmodule

`default_nettype wire

//--- design/zx_ports.sv
// I/O port block top: decode, paging lock, config registers, SD port and read mux
`default_nettype none

`include "zx_ports_macros.svh"

module zx_ports
  import zx_mem_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire [`ZX_ADDR_W-1:0] a,
  input  wire [`ZX_DATA_W-1:0] din,
  input  wire                  iowr_s,
  input  wire                  iord_s,
  input  wire                  iord,
  input  wire                  wr,
  input  wire                  regs_we,
  input  wire                  opfetch,
  input  wire [4:0]            keys_in,
  input  wire                  tape_read,
  input  wire [4:0]            kj_in,
  input  wire [7:0]            mus_in,
  input  wire [7:0]            sd_dataout,
  output logic                 porthit,
  output logic                 external_port,
  output logic                 dataout,
  output logic [`ZX_DATA_W-1:0] dout,
  output xt_page_t             xt_page,
  output logic [`ZX_DATA_W-1:0] memconf,
  output logic [`ZX_DATA_W-1:0] sysconf,
  output logic [3:0]           cacheconf,
  output logic [`ZX_DATA_W-1:0] intmask,
  output logic [4:0]           fmaddr,
  output logic                 sdcs_n,
  output logic                 sd_start,
  output logic [`ZX_DATA_W-1:0] sd_datain,
  output logic                 beeper_wr,
  output logic                 zborder_wr,
  output logic                 border_wr,
  output logic                 covox_wr
);

  logic [`ZX_DATA_W-1:0] hoa;
  logic                  xt_wr;
  logic                  xt_rd;
  logic                  p7ffd_req;
  logic                  p7ffd_wr;
  page_t                 page_7ffd;
  logic                  sdcfg_wr;
  logic                  sddat_wr;
  logic                  sddat_rd;

  assign zborder_wr = beeper_wr; // FE write also sets the border

  zx_port_decoder decoder_inst (
    .clk, .a, .regs_we, .iord, .iowr_s, .iord_s,
    .hoa, .porthit, .external_port, .dataout,
    .xt_wr, .xt_rd, .p7ffd_req, .beeper_wr, .border_wr, .covox_wr,
    .sdcfg_wr, .sddat_wr, .sddat_rd
  );

  paging_lock lock_inst (
    .clk, .rst, .din, .opfetch, .p7ffd_req, .memconf,
    .p7ffd_wr, .page_7ffd
  );

  xt_config_regs regs_inst (
    .clk, .rst, .din, .hoa, .xt_wr, .p7ffd_wr, .page_7ffd,
    .xt_page, .memconf, .sysconf, .cacheconf, .intmask, .fmaddr
  );

  sd_port sd_inst (
    .clk, .rst, .din, .wr, .sdcfg_wr, .sddat_wr, .sddat_rd,
    .sdcs_n, .sd_start, .sd_datain
  );

  port_read_mux rdmux_inst (
    .clk, .rst, .a, .hoa, .xt_rd, .keys_in, .tape_read, .kj_in, .mus_in,
    .sd_dataout, .xt_page, .dout
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// testbench clock and reset source: 40-unit clock period, reset held for 8 cycles
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #2 rst = 1'b0; // released with the other inputs
  end

endmodule

`default_nettype wire

//--- test/zx_ports_tb.sv
// testbench for the I/O port block with reference model, stimulus, compare process and report
`default_nettype none

`include "zx_ports_macros.svh"

module zx_ports_tb
  import zx_port_pkg::*;
  import zx_mem_pkg::*;
();

  localparam int max_cycles = 4000; // tests take about 450 cycles

  logic                  clk;
  logic                  rst;
  logic [`ZX_ADDR_W-1:0] a;
  logic [`ZX_DATA_W-1:0] din;
  logic                  iowr_s, iord_s, iord, wr, regs_we, opfetch;
  logic [4:0]            keys_in, kj_in;
  logic                  tape_read;
  logic [7:0]            mus_in, sd_dataout;
  logic                  porthit, external_port, dataout;
  logic [`ZX_DATA_W-1:0] dout, memconf, sysconf, intmask, sd_datain;
  xt_page_t              xt_page;
  logic [3:0]            cacheconf;
  logic [4:0]            fmaddr;
  logic                  sdcs_n, sd_start, beeper_wr, zborder_wr, border_wr, covox_wr;

  // model state
  xt_page_t              exp_pages;
  logic [`ZX_DATA_W-1:0] exp_memconf, exp_sysconf, exp_intmask, last_rd;
  logic [3:0]            exp_cacheconf;
  logic [4:0]            exp_fmaddr;
  logic                  fm_known, exp_sdcs_n, pwr_up_m, stat_m, m1_m, lock48_m;
  integer                seed = 20687;
  int                    err_count, check_count, test_count, test_errs, cycles;
  logic [7:0]            port_list [8];
  logic [7:0]            xt_list [9];

  tb_clock_gen clock_inst (.clk, .rst);

  zx_ports zx_ports_inst (
    .clk, .rst, .a, .din, .iowr_s, .iord_s, .iord, .wr, .regs_we, .opfetch,
    .keys_in, .tape_read, .kj_in, .mus_in, .sd_dataout,
    .porthit, .external_port, .dataout, .dout, .xt_page, .memconf, .sysconf,
    .cacheconf, .intmask, .fmaddr, .sdcs_n, .sd_start, .sd_datain,
    .beeper_wr, .zborder_wr, .border_wr, .covox_wr
  );

  function automatic logic ref_porthit(logic [7:0] lo);
    case (lo)
      8'hFE, 8'hFD, 8'hAF, 8'hFB, 8'h1F, 8'hDF, 8'h77, 8'h57: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic page_t ref_page_7ffd(logic [7:0] d, logic [7:0] mconf, logic m1);
    lock_mode_e mode;
    logic       lock;
    mode = lock_mode_e'(mconf[7:6]);
    lock = (mode == LOCK_M1) ? m1 : mconf[6];
    if (mode == LOCK_EXT)
      return {2'b00, d[5], d[7], d[6], d[2:0]}; // 1024K page
    else if (lock)
      return {5'b00000, d[2:0]};
    return {3'b000, d[7], d[6], d[2:0]};
  endfunction

  function automatic logic [7:0] ref_dout(logic [15:0] addr, logic stat, xt_page_t pages,
                                          logic [4:0] keys, logic tape, logic [4:0] kj,
                                          logic [7:0] mus, logic [7:0] sdo);
    case (addr[7:0])
      8'hFE: return {1'b1, tape, 1'b0, keys};
      8'hAF:
      begin
        if (addr[15:8] == 8'h00)
          return {1'b0, stat, 6'b000000};
        else if (addr[15:8] == 8'h12)
          return pages[2];
        else if (addr[15:8] == 8'h13)
          return pages[3];
        return 8'hFF;
      end
      8'h1F: return {3'b000, kj};
      8'hDF: return mus;
      8'h77: return 8'h00;
      8'h57: return sdo;
      default: return 8'hFF;
    endcase
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  task automatic check_bit(string name, logic got, logic exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("** Error at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_byte(string name, logic [`ZX_DATA_W-1:0] got,
                            logic [`ZX_DATA_W-1:0] exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_page(string name, xt_page_t got, xt_page_t exp);
    check_count++;
    if (got !== exp)
    begin
      err_count++;
      $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic bus_idle();
    iowr_s  = 1'b0;
    iord_s  = 1'b0;
    iord    = 1'b0;
    wr      = 1'b0;
    regs_we = 1'b0;
    opfetch = 1'b0;
  endtask

  // expected register state after one write
  task automatic model_write(logic [15:0] addr, logic [7:0] d, logic via_regs);
    logic [7:0] idx;
    idx = via_regs ? addr[7:0] : addr[15:8];
    if (!via_regs && addr[7:0] == 8'hFD && !addr[15] && !lock48_m)
    begin
      exp_pages[3] = ref_page_7ffd(d, exp_memconf, m1_m);
      if (exp_memconf[7:6] != 2'b11)
        lock48_m = d[5];
      exp_memconf[0] = d[4];
    end
    else if (via_regs || addr[7:0] == 8'hAF)
      case (idx)
        8'h10, 8'h11, 8'h12, 8'h13: exp_pages[idx[1:0]] = d;
        8'h15:
        begin
          exp_fmaddr = d[4:0];
          fm_known   = 1'b1;
        end
        8'h20:
        begin
          exp_sysconf   = d;
          exp_cacheconf = {4{d[2]}}; // turbo bit fills the cache enables
        end
        8'h21: exp_memconf = d;
        8'h2A: exp_intmask = d;
        8'h2B: exp_cacheconf = d[3:0];
        default: ;
      endcase
    if (!via_regs && addr[7:0] == 8'h77)
      exp_sdcs_n = d[1];
  endtask

  task automatic io_write(logic [15:0] addr, logic [7:0] d);
    a      = addr;
    din    = d;
    wr     = 1'b1;
    iowr_s = 1'b1;
    model_write(addr, d, 1'b0);
    wait_cycle();
    bus_idle();
  endtask

  task automatic regs_load(logic [15:0] addr, logic [7:0] d);
    a       = addr;
    din     = d;
    regs_we = 1'b1;
    model_write(addr, d, 1'b1);
    wait_cycle();
    bus_idle();
  endtask

  // strobe cycle followed by a data sample in the next cycle
  task automatic io_read(logic [15:0] addr);
    a      = addr;
    iord   = 1'b1;
    iord_s = 1'b1;
    if (addr == 16'h00AF)
    begin
      stat_m   = pwr_up_m;
      pwr_up_m = 1'b0;
    end
    wait_cycle();
    iord_s = 1'b0;
    #1;
    last_rd = dout;
    check_byte("dout", dout, ref_dout(addr, stat_m, exp_pages, keys_in, tape_read,
                                      kj_in, mus_in, sd_dataout));
    wait_cycle();
    bus_idle();
  endtask

  task automatic fetch(logic [7:0] d);
    opfetch = 1'b1;
    din     = d;
    m1_m    = !(d[7] ^ d[6]); // lock when opcode bits 7:6 agree
    wait_cycle();
    bus_idle();
  endtask

  task automatic check_regs();
    check_page("xt_page", xt_page, exp_pages);
    check_byte("memconf", memconf, exp_memconf);
    check_byte("sysconf", sysconf, exp_sysconf);
    check_byte("cacheconf", {4'h0, cacheconf}, {4'h0, exp_cacheconf});
    check_byte("intmask", intmask, exp_intmask);
    if (fm_known)
      check_byte("fmaddr", {3'b000, fmaddr}, {3'b000, exp_fmaddr});
    else
      check_bit("fmaddr[4]", fmaddr[4], 1'b0);
    check_bit("sdcs_n", sdcs_n, exp_sdcs_n);
  endtask

  task automatic finish_test(string name);
    test_count++;
    if (err_count == test_errs)
      $display("test %0d, %s: no errors", test_count, name);
    else
      $display("test %0d, %s: %0d errors", test_count, name, err_count - test_errs);
    test_errs = err_count;
  endtask

  // decode and strobe outputs checked against the port rules at mid-cycle
  always @(negedge clk)
  begin
    logic [7:0] lo;
    logic [7:0] idx;
    lo  = a[7:0];
    idx = regs_we ? lo : a[15:8];
    if (!rst)
    begin
      check_bit("porthit", porthit, ref_porthit(lo));
      check_bit("external_port", external_port, lo == 8'hFD && a[15]);
      check_bit("dataout", dataout, ref_porthit(lo) && iord && !(lo == 8'hFD && a[15]));
      check_bit("beeper_wr", beeper_wr, lo == 8'hFE && iowr_s);
      check_bit("zborder_wr", zborder_wr, lo == 8'hFE && iowr_s);
      check_bit("covox_wr", covox_wr, lo == 8'hFB && iowr_s);
      check_bit("border_wr", border_wr, (regs_we || (lo == 8'hAF && iowr_s)) && idx == 8'h0F);
      check_bit("sd_start", sd_start, lo == 8'h57 && (iowr_s || iord_s));
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > max_cycles)
    begin
      $display("timeout: run did not end within %0d cycles", max_cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    logic [7:0]  d, lo, hi, idx;
    page_t       held;
    port_list  = '{8'hFE, 8'hFD, 8'hAF, 8'hFB, 8'h1F, 8'hDF, 8'h77, 8'h57};
    xt_list    = '{XT_RAMPAGE0, XT_RAMPAGE1, XT_RAMPAGE2, XT_RAMPAGE3, XT_FMADDR,
                   XT_SYSCONF, XT_MEMCONF, XT_INTMASK, XT_CACHECONF};
    a          = '0;
    din        = '0;
    bus_idle();
    keys_in    = 5'h1F;
    tape_read  = 1'b0;
    kj_in      = '0;
    mus_in     = '0;
    sd_dataout = 8'hFF;
    exp_pages     = {8'h00, 8'h02, 8'h05, 8'h00}; // page 3 down to page 0
    exp_memconf   = 8'h04;
    exp_sysconf   = 8'h00;
    exp_cacheconf = 4'h0;
    exp_intmask   = 8'h01;
    exp_fmaddr    = 5'h00;
    fm_known      = 1'b0;
    exp_sdcs_n    = 1'b1;
    pwr_up_m      = 1'b1;
    stat_m        = 1'b0;
    m1_m          = 1'b0;
    lock48_m      = 1'b0;
    @(negedge rst);

    check_regs();
    check_page("reset pages", xt_page, {8'h00, 8'h02, 8'h05, 8'h00});
    io_read(16'h00AF);
    check_bit("first status bit 6", last_rd[6], 1'b1);
    io_read(16'h00AF);
    check_bit("second status bit 6", last_rd[6], 1'b0);
    finish_test("reset values and status");

    repeat (40)
    begin
      r   = $random(seed);
      idx = xt_list[r[7:4] % 4'd9];
      d   = rand_byte();
      if (r[8])
        regs_load({rand_byte(), idx}, d);
      else
        io_write({idx, 8'hAF}, d);
      check_regs();
      if (idx == 8'h12 || idx == 8'h13)
        io_read({idx, 8'hAF});
    end
    io_write(16'h20AF, 8'h04);
    check_byte("cacheconf after sysconf", {4'h0, cacheconf}, 8'h0F);
    io_write(16'h2BAF, 8'h05);
    check_regs();
    finish_test("extended register writes");

    for (int m = 0; m < 4; m++)
    begin
      d = rand_byte();
      io_write(16'h21AF, {m[1:0], d[5:0]});
      check_regs();
      repeat (6)
      begin
        fetch(rand_byte());
        d = rand_byte();
        if (m != 3)
          d[5] = 1'b0; // keep 48K lock open
        io_write(16'h7FFD, d);
        check_regs();
      end
    end
    io_write(16'hFFFD, rand_byte()); // AY select without paging
    check_regs();
    io_write(16'h21AF, 8'h00);
    io_write(16'h7FFD, 8'h23);
    check_regs();
    held = exp_pages[3];
    repeat (3)
    begin
      io_write(16'h7FFD, rand_byte());
      check_byte("page 3 under lock-48", xt_page[3], held);
      check_regs();
    end
    finish_test("7FFD paging and locks");

    repeat (200)
    begin
      r          = $random(seed);
      lo         = r[8] ? port_list[r[2:0]] : r[23:16];
      hi         = (r[11:10] == 2'd0) ? 8'h00 :
                   (r[11:10] == 2'd1) ? 8'h12 :
                   (r[11:10] == 2'd2) ? 8'h13 : r[31:24];
      a          = {hi, lo};
      iord       = r[12];
      keys_in    = r[17:13];
      tape_read  = r[18];
      kj_in      = r[28:24];
      mus_in     = rand_byte();
      sd_dataout = rand_byte();
      #1;
      check_byte("dout", dout, ref_dout(a, stat_m, exp_pages, keys_in, tape_read,
                                        kj_in, mus_in, sd_dataout));
      wait_cycle();
    end
    bus_idle();
    finish_test("random decode and read mux");

    io_write(16'h0077, 8'h02);
    check_regs();
    io_write(16'h0077, 8'hFD);
    check_regs();
    d      = rand_byte();
    a      = 16'h0057;
    din    = d;
    wr     = 1'b1;
    iowr_s = 1'b1;
    #1;
    check_bit("sd_start on write", sd_start, 1'b1);
    check_byte("sd_datain on write", sd_datain, d);
    wait_cycle();
    bus_idle();
    #1;
    check_bit("sd_start idle", sd_start, 1'b0);
    check_byte("sd_datain idle", sd_datain, 8'hFF);
    wait_cycle();
    io_read(16'h0057);
    finish_test("SD port");

    foreach (port_list[i])
      io_write({8'h0F, port_list[i]}, rand_byte());
    regs_load(16'h120F, rand_byte());
    check_regs();
    finish_test("write strobes");

    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- zx_ports.f
+incdir+design
design/zx_port_pkg.sv
design/zx_mem_pkg.sv
design/zx_port_decoder.sv
design/paging_lock.sv
design/xt_config_regs.sv
design/sd_port.sv
design/port_read_mux.sv
design/zx_ports.sv
test/tb_clock_gen.sv
test/zx_ports_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = zx_ports_tb
FILELIST  = zx_ports.f
OBJDIR    = obj_dir

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary -j 0 $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: build
	@out="$$($(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJDIR)
